/* Bender.yml */
package:
  name: rf_axil

sources:
  - rf_pkg.sv
  - rf_array_64x34.sv
  - rf_pg_64x33.sv
  - rf_wr_ctrl.sv
  - rf_rd_ctrl.sv
  - rf_pwr_ctrl.sv
  - rf_axil_top.sv
  - target: test
    files:
      - rf_axil_properties.sv
      - tb_rf_axil.sv

/* rf_array_64x34.sv */
`timescale 1ns/1ps

module rf_array_64x34
    import rf_pkg::*;
(
     input  logic        wclk
    ,input  logic        we
    ,input  rf_addr_t    waddr
    ,input  logic [33:0] wdata

    ,input  logic        rclk
    ,input  logic        re
    ,input  rf_addr_t    raddr
    ,output logic [33:0] rdata

    ,input  logic        ip_reset_b
    ,input  logic        pgcb_isol_en
    ,input  logic        pwr_enable_b_in
    ,output logic        pwr_enable_b_out
);

    logic [33:0]            mem [RF_DEPTH];
    logic [WAKE_CYCLES-1:0] pwr_chain;
    logic                   pwr_off;

    // ----------------------------------------
    // Power-enable chain
    // ----------------------------------------

    // The enable ripples through the array's power switches one stage per cycle
    always_ff @(posedge wclk) begin
        pwr_chain <= {pwr_chain[WAKE_CYCLES-2:0], pwr_enable_b_in};
    end

    // The last stage tells the sequencer that the whole array follows the request
    assign pwr_enable_b_out = pwr_chain[WAKE_CYCLES-1];
    assign pwr_off          = pwr_chain[WAKE_CYCLES-1];

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Without supply the bit cells float high, so every word reads back as ones
    // Writes are lost until the chain reports power on again
    always_ff @(posedge wclk) begin
        if (pwr_off) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                mem[i] <= '1;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read register, clamped to zero while the outputs are isolated or in reset
    always_ff @(posedge rclk) begin
        if (!ip_reset_b || pgcb_isol_en) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* rf_axil.f */
rf_pkg.sv
rf_array_64x34.sv
rf_pg_64x33.sv
rf_wr_ctrl.sv
rf_rd_ctrl.sv
rf_pwr_ctrl.sv
rf_axil_top.sv
rf_axil_properties.sv
tb_rf_axil.sv

/* rf_axil_properties.sv */
`timescale 1ns/1ps

module rf_axil_properties
    import rf_pkg::*;
(
     input logic         clk
    ,input logic         arst_n
    ,input axil_wr_req_t wr_req
    ,input axil_wr_rsp_t wr_rsp
    ,input axil_rd_req_t rd_req
    ,input axil_rd_rsp_t rd_rsp
    ,input rf_rd_t       mem_rd
    ,input logic         powered
    ,input logic         pgcb_isol_en
    ,input logic         pwr_enable_b_out
);

    // Number of assertion failures so far, read by the testbench
    int fail_cnt = 0;

    // ----------------------------------------
    // Response channels
    // ----------------------------------------

    // A stalled B beat keeps its valid and its response code
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp))
        else begin
            $error("bvalid dropped or bresp changed before the host took it");
            fail_cnt++;
        end

    // Same for R, data included
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rd_rsp.rvalid && !rd_req.rready |=>
            rd_rsp.rvalid && $stable(rd_rsp.rresp) && $stable(rd_rsp.rdata))
        else begin
            $error("rvalid dropped or the R payload changed before the host took it");
            fail_cnt++;
        end

    // Array read to R beat is a fixed two-cycle path
    a_read_latency: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rd.re |-> ##2 rd_rsp.rvalid)
        else begin
            $error("rvalid did not follow the array read two cycles later");
            fail_cnt++;
        end

    // ----------------------------------------
    // Power sequencing
    // ----------------------------------------

    // While the array still reports its supply off, its outputs stay isolated
    // and the host is never told that it is powered
    a_off_isolated: assert property (@(posedge clk) disable iff (!arst_n)
        pwr_enable_b_out |-> pgcb_isol_en && !powered)
        else begin
            $error("array reports power off while not isolated or while marked powered");
            fail_cnt++;
        end

endmodule

bind rf_axil_top rf_axil_properties u_props (
     .clk              (clk)
    ,.arst_n           (arst_n)
    ,.wr_req           (wr_req)
    ,.wr_rsp           (wr_rsp)
    ,.rd_req           (rd_req)
    ,.rd_rsp           (rd_rsp)
    ,.mem_rd           (mem_rd)
    ,.powered          (powered)
    ,.pgcb_isol_en     (pgcb_isol_en)
    ,.pwr_enable_b_out (pwr_enable_b_out)
);

/* rf_axil_top.sv */
`timescale 1ns/1ps

module rf_axil_top
    import rf_pkg::*;
(
     input  logic         clk
    ,input  logic         arst_n
    ,input  axil_wr_req_t wr_req
    ,output axil_wr_rsp_t wr_rsp
    ,input  axil_rd_req_t rd_req
    ,output axil_rd_rsp_t rd_rsp
);

    rf_wr_t   mem_wr;
    rf_rd_t   mem_rd;
    rf_word_t mem_rdata;
    logic     pwr_req;
    logic     powered;
    logic     pwr_enable_b_in;
    logic     pwr_enable_b_out;
    logic     pgcb_isol_en;

    // ----------------------------------------
    // Bus controllers
    // ----------------------------------------

    rf_wr_ctrl u_wr_ctrl (
         .clk     (clk)
        ,.arst_n  (arst_n)
        ,.req     (wr_req)
        ,.powered (powered)
        ,.rsp     (wr_rsp)
        ,.mem_wr  (mem_wr)
        ,.pwr_req (pwr_req)
    );

    rf_rd_ctrl u_rd_ctrl (
         .clk     (clk)
        ,.arst_n  (arst_n)
        ,.req     (rd_req)
        ,.powered (powered)
        ,.pwr_req (pwr_req)
        ,.rdata   (mem_rdata)
        ,.rsp     (rd_rsp)
        ,.mem_rd  (mem_rd)
    );

    rf_pwr_ctrl u_pwr_ctrl (
         .clk              (clk)
        ,.arst_n           (arst_n)
        ,.pwr_req          (pwr_req)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.powered          (powered)
    );

    // ----------------------------------------
    // Memory, both ports on the one clock
    // ----------------------------------------

    rf_pg_64x33 u_mem (
         .wclk             (clk)
        ,.wclk_rst_n       (arst_n)
        ,.we               (mem_wr.we)
        ,.waddr            (mem_wr.waddr)
        ,.wdata            (mem_wr.wdata)
        ,.rclk             (clk)
        ,.rclk_rst_n       (arst_n)
        ,.re               (mem_rd.re)
        ,.raddr            (mem_rd.raddr)
        ,.rdata            (mem_rdata)
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.ip_reset_b       (arst_n)
    );

endmodule

/* rf_pg_64x33.sv */
`timescale 1ns/1ps

module rf_pg_64x33
    import rf_pkg::*;
(
     input  logic     wclk
    ,input  logic     wclk_rst_n
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_word_t wdata

    ,input  logic     rclk
    ,input  logic     rclk_rst_n
    ,input  logic     re
    ,input  rf_addr_t raddr
    ,output rf_word_t rdata

    // Power interface
    ,input  logic     pgcb_isol_en
    ,input  logic     pwr_enable_b_in
    ,output logic     pwr_enable_b_out

    ,input  logic     ip_reset_b
);

    logic [33:0] wdata_pad;
    logic [33:0] rdata_pad;
    logic [1:0]  rst_sync;
    logic        rst_src_n;
    logic        we_gated;

    // ----------------------------------------
    // Array reset synchronizer
    // ----------------------------------------

    // Either reset source asserts at once and releases two rclk edges later
    assign rst_src_n = ip_reset_b && rclk_rst_n;

    always_ff @(posedge rclk or negedge rst_src_n) begin
        if (!rst_src_n) begin
            rst_sync <= '0;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    // No write reaches the array while its write domain is held in reset
    assign we_gated = we && wclk_rst_n;

    // The physical array is one bit wider than the stored word
    assign wdata_pad = {1'b0, wdata};

    rf_array_64x34 u_array (
         .wclk             (wclk)
        ,.we               (we_gated)
        ,.waddr            (waddr)
        ,.wdata            (wdata_pad)
        ,.rclk             (rclk)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata_pad)
        ,.ip_reset_b       (rst_sync[1])
        ,.pgcb_isol_en     (pgcb_isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // Spare top bit is dropped on the way out
    assign rdata = rdata_pad[$bits(rf_word_t)-1:0];

endmodule

/* rf_pkg.sv */
package rf_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // AXI4-Lite bus fields
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    // Array index and stored word, parity sits in bit 32
    typedef logic [5:0]  rf_addr_t;
    typedef logic [32:0] rf_word_t;

    localparam int RF_DEPTH = 64;

    // Power-chain delay of the array, in clock cycles
    localparam int WAKE_CYCLES = 4;

    // ----------------------------------------
    // Address map and responses
    // ----------------------------------------

    localparam axil_addr_t DATA_BASE   = 12'h000;
    localparam axil_addr_t DATA_LAST   = 12'h0FC;
    localparam axil_addr_t CTRL_ADDR   = 12'h100;
    localparam axil_addr_t STATUS_ADDR = 12'h104;

    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;

    // Power sequencer states
    typedef enum logic [1:0] {
        PWR_OFF,
        PWR_WAKE,
        PWR_ON,
        PWR_ISOLATE
    } pwr_state_e;

    // ----------------------------------------
    // Bus and memory-port bundles
    // ----------------------------------------

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rd_rsp_t;

    typedef struct packed {
        logic     we;
        rf_addr_t waddr;
        rf_word_t wdata;
    } rf_wr_t;

    typedef struct packed {
        logic     re;
        rf_addr_t raddr;
    } rf_rd_t;

endpackage

/* rf_pwr_ctrl.sv */
`timescale 1ns/1ps

module rf_pwr_ctrl
    import rf_pkg::*;
(
     input  logic clk
    ,input  logic arst_n
    ,input  logic pwr_req
    ,input  logic pwr_enable_b_out
    ,output logic pwr_enable_b_in
    ,output logic pgcb_isol_en
    ,output logic powered
);

    pwr_state_e state;
    pwr_state_e state_nxt;

    // ----------------------------------------
    // State register
    // ----------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= PWR_OFF;
        end else begin
            state <= state_nxt;
        end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            // Waits until the chain has fully switched off, so a quick
            // re-request still sees the contents lost
            PWR_OFF: begin
                if (pwr_req && pwr_enable_b_out) begin
                    state_nxt = PWR_WAKE;
                end
            end
            // A wake-up always completes, a late off request is handled from ON
            PWR_WAKE: begin
                if (!pwr_enable_b_out) begin
                    state_nxt = PWR_ON;
                end
            end
            PWR_ON: begin
                if (!pwr_req) begin
                    state_nxt = PWR_ISOLATE;
                end
            end
            // One cycle of isolation before the supply is removed
            PWR_ISOLATE: begin
                state_nxt = PWR_OFF;
            end
            default: begin
                state_nxt = PWR_OFF;
            end
        endcase
    end

    // Outputs decode straight from the state register
    // Enable is low from the start of wake until isolation has been applied
    assign pwr_enable_b_in = (state == PWR_OFF);
    assign pgcb_isol_en    = (state != PWR_ON);
    assign powered         = (state == PWR_ON);

endmodule

/* rf_rd_ctrl.sv */
`timescale 1ns/1ps

module rf_rd_ctrl
    import rf_pkg::*;
(
     input  logic         clk
    ,input  logic         arst_n
    ,input  axil_rd_req_t req
    ,input  logic         powered
    ,input  logic         pwr_req
    ,input  rf_word_t     rdata
    ,output axil_rd_rsp_t rsp
    ,output rf_rd_t       mem_rd
);

    logic       arready;
    logic       accept;
    logic       p1_valid;
    logic       p1_data;
    logic       p1_ctrl;
    logic       p1_status;
    logic       p1_powered;
    logic       parity_err;
    logic       rvalid;
    axil_data_t rdata_d;
    axil_resp_t rresp_d;
    axil_data_t rdata_q;
    axil_resp_t rresp_q;

    // ----------------------------------------
    // AR acceptance and array read
    // ----------------------------------------

    // One read in flight at a time, from AR transfer until the R beat is taken
    assign arready = !p1_valid && !rvalid;
    assign accept  = req.arvalid && arready;

    // The array is read on every accepted address, the result is used for data words only
    assign mem_rd.re    = accept;
    assign mem_rd.raddr = req.araddr[2 +: $bits(rf_addr_t)];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            p1_valid <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            p1_valid <= accept;
            if (p1_valid) begin
                rvalid <= 1'b1;
            end else if (req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Address class and power state are frozen at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            p1_data    <= (req.araddr >= DATA_BASE) && (req.araddr <= DATA_LAST);
            p1_ctrl    <= (req.araddr == CTRL_ADDR);
            p1_status  <= (req.araddr == STATUS_ADDR);
            p1_powered <= powered;
        end
    end

    // ----------------------------------------
    // Parity check and R response
    // ----------------------------------------

    // A good word has an even number of ones over data and parity
    assign parity_err = ^rdata;

    always_comb begin
        rdata_d = '0;
        rresp_d = RESP_SLVERR;
        if (p1_data) begin
            // Powered-down reads return nothing, a bad word still returns its data
            if (p1_powered) begin
                rdata_d = rdata[31:0];
                rresp_d = parity_err ? RESP_SLVERR : RESP_OKAY;
            end
        end else if (p1_ctrl) begin
            rdata_d = {31'd0, pwr_req};
            rresp_d = RESP_OKAY;
        end else if (p1_status) begin
            rdata_d = {31'd0, powered};
            rresp_d = RESP_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (p1_valid) begin
            rdata_q <= rdata_d;
            rresp_q <= rresp_d;
        end
    end

    assign rsp.arready = arready;
    assign rsp.rvalid  = rvalid;
    assign rsp.rdata   = rdata_q;
    assign rsp.rresp   = rresp_q;

endmodule

/* rf_wr_ctrl.sv */
`timescale 1ns/1ps

module rf_wr_ctrl
    import rf_pkg::*;
(
     input  logic         clk
    ,input  logic         arst_n
    ,input  axil_wr_req_t req
    ,input  logic         powered
    ,output axil_wr_rsp_t rsp
    ,output rf_wr_t       mem_wr
    ,output logic         pwr_req
);

    logic       accept;
    logic       in_data;
    logic       full_strb;
    logic       data_ok;
    logic       ctrl_hit;
    logic       bvalid;
    axil_resp_t bresp;
    axil_resp_t resp_d;

    // ----------------------------------------
    // Acceptance and decode
    // ----------------------------------------

    // AW and W are taken together, and only once the previous B beat has left
    assign accept = req.awvalid && req.wvalid && !bvalid;

    assign in_data   = (req.awaddr >= DATA_BASE) && (req.awaddr <= DATA_LAST);
    assign full_strb = &req.wstrb;
    assign ctrl_hit  = (req.awaddr == CTRL_ADDR);

    // A data word needs all bytes since parity covers the full word
    assign data_ok = in_data && full_strb && powered;

    // Status register is read-only and falls into the error case here
    assign resp_d = (data_ok || ctrl_hit) ? RESP_OKAY : RESP_SLVERR;

    // ----------------------------------------
    // Array write port
    // ----------------------------------------

    assign mem_wr.we    = accept && data_ok;
    assign mem_wr.waddr = req.awaddr[2 +: $bits(rf_addr_t)];
    // Even parity, so the stored word always holds an even count of ones
    assign mem_wr.wdata = {^req.wdata, req.wdata};

    // ----------------------------------------
    // Control register and B channel
    // ----------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid  <= 1'b0;
            pwr_req <= 1'b0;
        end else begin
            if (accept) begin
                bvalid <= 1'b1;
            end else if (req.bready) begin
                bvalid <= 1'b0;
            end
            // Only the low byte lane carries the power request
            if (accept && ctrl_hit && req.wstrb[0]) begin
                pwr_req <= req.wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bresp <= resp_d;
        end
    end

    assign rsp.awready = accept;
    assign rsp.wready  = accept;
    assign rsp.bvalid  = bvalid;
    assign rsp.bresp   = bresp;

endmodule

/* tb_rf_axil.sv */
`timescale 1ns/1ps

module tb_rf_axil
    import rf_pkg::*;
();

    // ----------------------------------------
    // Run limits
    // ----------------------------------------

    localparam int N_RANDOM   = 40;
    localparam int HS_LIMIT   = 16;
    localparam int MAX_STALL  = 7;
    localparam int POLL_LIMIT = 20;
    // Two handshakes, the longest stall and some slack per transaction
    localparam int TXN_BOUND  = 2 * HS_LIMIT + MAX_STALL + 4;
    localparam int N_TXN      = 4 * N_RANDOM + 32;
    // Three power transitions, each polled at most POLL_LIMIT times
    localparam int MAX_CYCLES = 16 + (N_TXN + 3 * POLL_LIMIT) * TXN_BOUND;

    logic         clk;
    logic         arst_n;
    axil_wr_req_t wr_req;
    axil_wr_rsp_t wr_rsp;
    axil_rd_req_t rd_req;
    axil_rd_rsp_t rd_rsp;

    integer       seed = 32'h7424_acca;
    int           err_cnt;
    int           chk_cnt;
    int           test_cnt;
    int           test_fail_cnt;
    int           test_err_start;
    int           cycles;

    // Reference model of the data words, the power request and the power state
    axil_data_t   model_mem [RF_DEPTH];
    logic         model_vld [RF_DEPTH];
    logic         model_req;
    logic         model_pwr;
    rf_addr_t     written [$];

    rf_axil_top dut (
         .clk    (clk)
        ,.arst_n (arst_n)
        ,.wr_req (wr_req)
        ,.wr_rsp (wr_rsp)
        ,.rd_req (rd_req)
        ,.rd_rsp (rd_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run is cut off when the tests overrun their worked-out length
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles because the tests did not finish", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic axil_resp_t model_write(input axil_addr_t addr, input axil_data_t data,
                                               input axil_strb_t strb);
        if (addr >= DATA_BASE && addr <= DATA_LAST) begin
            if (strb == 4'hF && model_pwr) begin
                model_mem[addr[7:2]] = data;
                model_vld[addr[7:2]] = 1'b1;
                return RESP_OKAY;
            end
            return RESP_SLVERR;
        end
        if (addr == CTRL_ADDR) begin
            model_req = data[0];
            // Dropping the request powers the array down and every word is lost
            if (!data[0]) begin
                for (int i = 0; i < RF_DEPTH; i++) begin
                    model_vld[i] = 1'b0;
                end
            end
            return RESP_OKAY;
        end
        return RESP_SLVERR;
    endfunction

    task automatic model_read(input axil_addr_t addr, output axil_resp_t resp,
                              output axil_data_t data);
        resp = RESP_SLVERR;
        data = '0;
        if (addr >= DATA_BASE && addr <= DATA_LAST) begin
            // A lost word reads back as all ones, which fails parity
            if (model_pwr) begin
                data = model_vld[addr[7:2]] ? model_mem[addr[7:2]] : 32'hFFFF_FFFF;
                resp = model_vld[addr[7:2]] ? RESP_OKAY : RESP_SLVERR;
            end
        end else if (addr == CTRL_ADDR) begin
            data = {31'd0, model_req};
            resp = RESP_OKAY;
        end else if (addr == STATUS_ADDR) begin
            data = {31'd0, model_pwr};
            resp = RESP_OKAY;
        end
    endtask

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    task automatic check_wr_rsp(input axil_resp_t got, input axil_resp_t exp,
                                input string what);
        chk_cnt++;
        if (got !== exp) begin
            $display("MISMATCH @%0t: %s bresp %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_rd_rsp(input axil_resp_t got_resp, input axil_resp_t exp_resp,
                                input axil_data_t got_data, input axil_data_t exp_data,
                                input string what);
        chk_cnt++;
        if (got_resp !== exp_resp || got_data !== exp_data) begin
            $display("MISMATCH @%0t: %s got %0d/0x%h, expected %0d/0x%h", $time, what,
                     got_resp, got_data, exp_resp, exp_data);
            err_cnt++;
        end
    endtask

    // Errors seen by the tasks plus failures of the bound assertions
    function automatic int error_total();
        return err_cnt + dut.u_props.fail_cnt;
    endfunction

    // ----------------------------------------
    // AXI4-Lite host tasks
    // ----------------------------------------

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb, input int stall,
                              output axil_resp_t resp);
        int n;
        resp = 'x;
        @(posedge clk);
        wr_req.awvalid <= 1'b1;
        wr_req.awaddr  <= addr;
        wr_req.wvalid  <= 1'b1;
        wr_req.wdata   <= data;
        wr_req.wstrb   <= strb;
        wr_req.bready  <= (stall == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wr_rsp.awready && !wr_rsp.wready && n < HS_LIMIT);
        // Address and data are only ever taken together
        if (!wr_rsp.awready || !wr_rsp.wready) begin
            $display("ERROR @%0t: write to 0x%h was not accepted on both AW and W",
                     $time, addr);
            err_cnt++;
            return;
        end
        // Transfer happens on this edge, so the beats drop right after it
        @(posedge clk);
        wr_req.awvalid <= 1'b0;
        wr_req.wvalid  <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wr_rsp.bvalid && n < HS_LIMIT);
        if (!wr_rsp.bvalid) begin
            $display("ERROR @%0t: no write response came for 0x%h", $time, addr);
            err_cnt++;
            return;
        end
        resp = wr_rsp.bresp;
        // While the host stalls the response has to stay as it is
        repeat (stall) begin
            @(negedge clk);
            if (!wr_rsp.bvalid || wr_rsp.bresp !== resp) begin
                $display("MISMATCH @%0t: write response for 0x%h changed while stalled",
                         $time, addr);
                err_cnt++;
            end
        end
        @(posedge clk);
        wr_req.bready <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (wr_rsp.bvalid && n < HS_LIMIT);
        if (wr_rsp.bvalid) begin
            $display("ERROR @%0t: write response for 0x%h was never retired", $time, addr);
            err_cnt++;
        end
    endtask

    task automatic axil_read(input axil_addr_t addr, input int stall,
                             output axil_resp_t resp, output axil_data_t data);
        int n;
        resp = 'x;
        data = 'x;
        @(posedge clk);
        rd_req.arvalid <= 1'b1;
        rd_req.araddr  <= addr;
        rd_req.rready  <= (stall == 0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rd_rsp.arready && n < HS_LIMIT);
        if (!rd_rsp.arready) begin
            $display("ERROR @%0t: read of 0x%h was never accepted", $time, addr);
            err_cnt++;
            return;
        end
        @(posedge clk);
        rd_req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rd_rsp.rvalid && n < HS_LIMIT);
        if (!rd_rsp.rvalid) begin
            $display("ERROR @%0t: no read response came for 0x%h", $time, addr);
            err_cnt++;
            return;
        end
        resp = rd_rsp.rresp;
        data = rd_rsp.rdata;
        repeat (stall) begin
            @(negedge clk);
            if (!rd_rsp.rvalid || rd_rsp.rresp !== resp || rd_rsp.rdata !== data) begin
                $display("MISMATCH @%0t: read response for 0x%h changed while stalled",
                         $time, addr);
                err_cnt++;
            end
        end
        @(posedge clk);
        rd_req.rready <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rd_rsp.rvalid && n < HS_LIMIT);
        if (rd_rsp.rvalid) begin
            $display("ERROR @%0t: read response for 0x%h was never retired", $time, addr);
            err_cnt++;
        end
    endtask

    // Issue one transaction and compare it with the model
    task automatic do_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, input int stall, input string what);
        axil_resp_t exp;
        axil_resp_t got;
        exp = model_write(addr, data, strb);
        axil_write(addr, data, strb, stall, got);
        check_wr_rsp(got, exp, $sformatf("%s 0x%h", what, addr));
    endtask

    task automatic do_read(input axil_addr_t addr, input int stall, input string what);
        axil_resp_t exp_resp;
        axil_data_t exp_data;
        axil_resp_t got_resp;
        axil_data_t got_data;
        model_read(addr, exp_resp, exp_data);
        axil_read(addr, stall, got_resp, got_data);
        check_rd_rsp(got_resp, exp_resp, got_data, exp_data, $sformatf("%s 0x%h", what, addr));
    endtask

    // Poll the status register until the powered bit shows the wanted value
    task automatic wait_power(input logic want);
        axil_resp_t resp;
        axil_data_t data;
        int         polls;
        polls = 0;
        do begin
            axil_read(STATUS_ADDR, 0, resp, data);
            polls++;
        end while (data[0] !== want && polls < POLL_LIMIT);
        if (data[0] !== want) begin
            $display("ERROR @%0t: power status did not reach %0b within %0d polls",
                     $time, want, POLL_LIMIT);
            err_cnt++;
        end
        model_pwr = want;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_total();
        test_cnt++;
        if (errs == test_err_start) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail_cnt++;
            $display("test %0d %s: failed with %0d errors", test_cnt, name,
                     errs - test_err_start);
        end
        test_err_start = errs;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    initial begin
        rf_addr_t   idx;
        axil_data_t data;
        int         stall;
        int         found;
        int         i;

        wr_req = '0;
        rd_req = '0;
        arst_n = 1'b0;
        err_cnt = 0;
        chk_cnt = 0;
        test_cnt = 0;
        test_fail_cnt = 0;
        test_err_start = 0;
        model_req = 1'b0;
        model_pwr = 1'b0;
        for (i = 0; i < RF_DEPTH; i++) begin
            model_mem[i] = '0;
            model_vld[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Power-up through the control register
        do_write(CTRL_ADDR, 32'd1, 4'hF, 0, "power on");
        wait_power(1'b1);
        do_read(CTRL_ADDR, 0, "control");
        finish_test("power_up");

        // Full-strobe writes, then every written word is read back
        for (i = 0; i < N_RANDOM; i++) begin
            idx  = rf_addr_t'($random(seed));
            data = $random(seed);
            written.push_back(idx);
            do_write({4'h0, idx, 2'b00}, data, 4'hF, 0, "write");
        end
        foreach (written[k]) begin
            do_read({4'h0, written[k], 2'b00}, 0, "read");
        end
        finish_test("write_read");

        // A few words that were never written read back as lost
        found = 0;
        for (i = 0; i < RF_DEPTH && found < 3; i++) begin
            if (!model_vld[i]) begin
                do_read(axil_addr_t'(i * 4), 0, "unwritten");
                found++;
            end
        end
        finish_test("unwritten");

        // Error cases, each followed by a read of the word it could have hit
        idx = written[0];
        do_write({4'h0, idx, 2'b00}, ~model_mem[idx], 4'b0111, 0, "partial");
        do_read({4'h0, idx, 2'b00}, 0, "after partial");
        do_write(STATUS_ADDR, 32'hFFFF_FFFF, 4'hF, 0, "status");
        do_read(12'h004, 0, "after status");
        do_write(12'h200, 32'h1234_5678, 4'hF, 0, "unmapped");
        do_read(12'h000, 0, "after unmapped");
        do_read(12'h200, 0, "unmapped");
        do_read(12'h108, 0, "unmapped");
        finish_test("errors");

        // Power-down loses the contents
        do_write(CTRL_ADDR, 32'd0, 4'hF, 0, "power off");
        wait_power(1'b0);
        do_write({4'h0, written[1], 2'b00}, 32'hA5A5_5A5A, 4'hF, 0, "write off");
        do_read({4'h0, written[1], 2'b00}, 0, "read off");
        do_read(CTRL_ADDR, 0, "control");
        do_write(CTRL_ADDR, 32'd1, 4'hF, 0, "power on");
        wait_power(1'b1);
        for (i = 0; i < 4; i++) begin
            do_read({4'h0, written[i], 2'b00}, 0, "lost");
        end
        finish_test("power_down");

        // Mixed traffic with random response stalls
        for (i = 0; i < N_RANDOM; i++) begin
            idx   = rf_addr_t'($random(seed));
            data  = $random(seed);
            stall = {$random(seed)} % (MAX_STALL + 1);
            if ($random(seed) & 1) begin
                do_write({4'h0, idx, 2'b00}, data, 4'hF, stall, "stalled write");
            end else begin
                do_read({4'h0, idx, 2'b00}, stall, "stalled read");
            end
        end
        finish_test("back_pressure");

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, test_fail_cnt, chk_cnt, err_cnt, dut.u_props.fail_cnt);
        if (error_total() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
